//--- logic/mem_sys_pkg.sv
// Bus widths, vector types, AXI response and prot codes, RAM geometry
package mem_sys_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and vector types
	////////////////////////////////////////////////////////////////////////////

	localparam int XLEN  = 32;					// One word
	localparam int BYTES = XLEN / 8;			// Byte lanes per word

	typedef logic [XLEN-1:0]  addr_t;			// Byte address
	typedef logic [XLEN-1:0]  data_t;			// Data word
	typedef logic [BYTES-1:0] strb_t;			// Byte enables / write strobes
	typedef logic [1:0]       resp_t;			// AXI response code
	typedef logic [2:0]       prot_t;			// AXI protection bits

	////////////////////////////////////////////////////////////////////////////
	// AXI codes
	////////////////////////////////////////////////////////////////////////////

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;		// No slave at this address

	// Unprivileged, secure, data access
	localparam prot_t PROT_DATA = 3'b000;

	////////////////////////////////////////////////////////////////////////////
	// Addressing and RAM geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int WORD_OFFSET_BITS = $clog2(BYTES);	// Byte offset within a word

	// Clears the byte offset bits
	localparam addr_t WORD_ALIGN_MASK = ~addr_t'(BYTES - 1);

	localparam int RAM_WORDS      = 256;
	localparam int RAM_INDEX_BITS = $clog2(RAM_WORDS);	// Word select width

	// Bits 9:2 pick the word, anything set above bit 9 is out of range

endpackage : mem_sys_pkg

//--- logic/axil_if.sv
// AXI4-Lite interface with the five channels and master/slave modports
`timescale 1ns/1ns

interface axil_if import mem_sys_pkg::*; ();

	// Write address channel
	addr_t awaddr;
	prot_t awprot;
	logic  awvalid;
	logic  awready;

	// Write data channel
	data_t wdata;
	strb_t wstrb;
	logic  wvalid;
	logic  wready;

	// Write response channel
	resp_t bresp;
	logic  bvalid;
	logic  bready;

	// Read address channel
	addr_t araddr;
	prot_t arprot;
	logic  arvalid;
	logic  arready;

	// Read data channel
	data_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;

	modport master (
		output awaddr, awprot, awvalid, input awready,
		output wdata, wstrb, wvalid, input wready,
		input bresp, bvalid, output bready,
		output araddr, arprot, arvalid, input arready,
		input rdata, rresp, rvalid, output rready
	);

	modport slave (
		input awaddr, awprot, awvalid, output awready,
		input wdata, wstrb, wvalid, output wready,
		output bresp, bvalid, input bready,
		input araddr, arprot, arvalid, output arready,
		output rdata, rresp, rvalid, input rready
	);

endinterface : axil_if

//--- logic/mem_sys_axil.sv
// AXI4-Lite master FSM turning core read/write requests into channel handshakes
`timescale 1ns/1ns

module mem_sys_axil import mem_sys_pkg::*; (
	input	logic		clk,
	input	logic		rst_n,

	// Core request port
	input	addr_t		addr,			// Byte address, aligned here
	input	data_t		data_in,
	input	logic		wr,
	input	logic		rd,
	input	logic		valid,
	input	strb_t		be,				// Write only

	output	data_t		data_out,		// Valid while done is high
	output	logic		done,
	output	logic		err,			// Non-OKAY response

	axil_if.master		bus
);

	typedef enum logic [2:0] {
		IDLE,
		R_ADDR,			// Address still owed
		R_DATA,			// Waiting for r
		W_ADDR,			// Address owed, data maybe
		W_DATA,			// Only data owed
		W_RESP,			// Waiting for b
		BAD				// Impossible handshake order seen
	} state_t;

	state_t	state, state_nxt;
	logic	w_sent, w_sent_nxt;			// Data went out while still in W_ADDR

	logic	rden, wren;
	logic	reading, writing;

	logic	ar_hs, r_hs, aw_hs, w_hs, b_hs;
	logic	ar_owed, aw_owed, w_owed;
	logic	ar_left, aw_left, w_left;

	assign rden = valid & rd;
	assign wren = valid & wr & ~rd;		// Read wins if both are raised

	////////////////////////////////////////////////////////////////////////////
	// State registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			w_sent <= 1'b0;
		end else begin
			state  <= state_nxt;
			w_sent <= w_sent_nxt;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Channel handshakes and owed channels
	////////////////////////////////////////////////////////////////////////////

	assign ar_hs = bus.arvalid & bus.arready;
	assign r_hs  = bus.rvalid  & bus.rready;
	assign aw_hs = bus.awvalid & bus.awready;
	assign w_hs  = bus.wvalid  & bus.wready;
	assign b_hs  = bus.bvalid  & bus.bready;

	assign reading = (state == IDLE && rden) || state == R_ADDR || state == R_DATA;
	assign writing = (state == IDLE && wren) || state == W_ADDR ||
		state == W_DATA || state == W_RESP;

	// Which channels still have to transfer in this cycle
	always_comb begin
		ar_owed = 1'b0;
		aw_owed = 1'b0;
		w_owed  = 1'b0;
		case (state)
			IDLE: begin
				ar_owed = rden;
				aw_owed = wren;
				w_owed  = wren;
			end
			R_ADDR:	ar_owed = 1'b1;
			W_ADDR: begin
				aw_owed = 1'b1;
				w_owed  = ~w_sent;		// Dropped once data has gone
			end
			W_DATA:	w_owed = 1'b1;
			default: ;					// R_DATA, W_RESP and BAD owe nothing
		endcase
	end

	// Still owed after this cycle's handshakes
	assign ar_left = ar_owed & ~ar_hs;
	assign aw_left = aw_owed & ~aw_hs;
	assign w_left  = w_owed  & ~w_hs;

	////////////////////////////////////////////////////////////////////////////
	// Bus drive
	////////////////////////////////////////////////////////////////////////////

	assign bus.awaddr  = addr & WORD_ALIGN_MASK;
	assign bus.awprot  = PROT_DATA;
	assign bus.awvalid = aw_owed;
	assign bus.wdata   = data_in;
	assign bus.wstrb   = be;
	assign bus.wvalid  = w_owed;
	assign bus.bready  = 1'b1;			// Always able to take a response

	assign bus.araddr  = addr & WORD_ALIGN_MASK;
	assign bus.arprot  = PROT_DATA;
	assign bus.arvalid = ar_owed;
	assign bus.rready  = 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Next state and completion
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt  = state;
		w_sent_nxt = 1'b0;
		done       = 1'b0;
		err        = 1'b0;
		data_out   = '0;

		if (state == BAD) begin
			state_nxt = BAD;			// Locked until reset
		end else if (reading) begin
			if (r_hs) begin
				if (ar_left) begin
					state_nxt = BAD;	// Data before its address
				end else begin
					state_nxt = IDLE;
					done      = 1'b1;
					err       = (bus.rresp != RESP_OKAY);
					data_out  = bus.rdata;
				end
			end else if (ar_left) begin
				state_nxt = R_ADDR;
			end else begin
				state_nxt = R_DATA;
			end
		end else if (writing) begin
			if (b_hs) begin
				if (aw_left || w_left) begin
					state_nxt = BAD;	// Response before address or data
				end else begin
					state_nxt = IDLE;
					done      = 1'b1;
					err       = (bus.bresp != RESP_OKAY);
				end
			end else if (aw_left) begin
				state_nxt  = W_ADDR;
				w_sent_nxt = ~w_left;	// Data may already be through
			end else if (w_left) begin
				state_nxt = W_DATA;
			end else begin
				state_nxt = W_RESP;
			end
		end else begin
			state_nxt = IDLE;
		end
	end

endmodule : mem_sys_axil

//--- logic/axil_ram.sv
// AXI4-Lite RAM slave with byte strobes, address decode and DECERR response
`timescale 1ns/1ns

module axil_ram import mem_sys_pkg::*; (
	input	logic	clk,
	input	logic	rst_n,

	axil_if.slave	bus
);

	typedef logic [RAM_INDEX_BITS-1:0] ram_idx_t;

	data_t		mem [RAM_WORDS];

	// Write side holding registers
	logic		aw_held, w_held;
	addr_t		aw_addr_q;
	data_t		w_data_q;
	strb_t		w_strb_q;
	logic		bvalid_q;
	resp_t		bresp_q;

	// Read side
	logic		rvalid_q;
	addr_t		ar_addr_q;

	logic		aw_fire, w_fire, ar_fire;
	logic		do_write;
	addr_t		wr_addr;
	data_t		wr_data;
	strb_t		wr_strb;

	function automatic logic in_range(addr_t a);
		return a[XLEN-1:RAM_INDEX_BITS+WORD_OFFSET_BITS] == '0;
	endfunction

	function automatic ram_idx_t word_index(addr_t a);
		return a[WORD_OFFSET_BITS +: RAM_INDEX_BITS];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////////////////////

	assign bus.awready = ~bvalid_q & ~aw_held;
	assign bus.wready  = ~bvalid_q & ~w_held;

	assign aw_fire = bus.awvalid & bus.awready;
	assign w_fire  = bus.wvalid & bus.wready;

	// Both halves present, either held or arriving now
	assign do_write = (aw_held | aw_fire) & (w_held | w_fire);

	assign wr_addr = aw_held ? aw_addr_q : bus.awaddr;
	assign wr_data = w_held ? w_data_q : bus.wdata;
	assign wr_strb = w_held ? w_strb_q : bus.wstrb;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_held  <= 1'b0;
			w_held   <= 1'b0;
			bvalid_q <= 1'b0;
		end else if (do_write) begin
			aw_held  <= 1'b0;
			w_held   <= 1'b0;
			bvalid_q <= 1'b1;			// Response on the next cycle
		end else begin
			if (aw_fire)
				aw_held <= 1'b1;
			if (w_fire)
				w_held <= 1'b1;
			if (bvalid_q && bus.bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire)
			aw_addr_q <= bus.awaddr;
		if (w_fire) begin
			w_data_q <= bus.wdata;
			w_strb_q <= bus.wstrb;
		end
		if (do_write)
			bresp_q <= in_range(wr_addr) ? RESP_OKAY : RESP_DECERR;
	end

	// Strobed byte lanes, nothing written out of range
	always_ff @(posedge clk) begin
		if (do_write && in_range(wr_addr)) begin
			for (int b = 0; b < BYTES; b++) begin
				if (wr_strb[b])
					mem[word_index(wr_addr)][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

	assign bus.bvalid = bvalid_q;
	assign bus.bresp  = bresp_q;

	////////////////////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////////////////////

	assign bus.arready = ~rvalid_q;
	assign ar_fire     = bus.arvalid & bus.arready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rvalid_q <= 1'b0;
		else if (ar_fire)
			rvalid_q <= 1'b1;
		else if (rvalid_q && bus.rready)
			rvalid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (ar_fire)
			ar_addr_q <= bus.araddr;
	end

	// Word held on the bus until r is taken
	assign bus.rvalid = rvalid_q;
	assign bus.rdata  = in_range(ar_addr_q) ? mem[word_index(ar_addr_q)] : '0;
	assign bus.rresp  = in_range(ar_addr_q) ? RESP_OKAY : RESP_DECERR;

endmodule : axil_ram

//--- logic/mem_sys_top.sv
// Memory system top level joining the AXI4-Lite master and RAM slave
`timescale 1ns/1ns

module mem_sys_top import mem_sys_pkg::*; (
	input	logic	clk,
	input	logic	rst_n,

	// Core request port
	input	addr_t	addr,
	input	data_t	data_in,
	input	logic	wr,
	input	logic	rd,
	input	logic	valid,
	input	strb_t	be,

	output	data_t	data_out,
	output	logic	done,
	output	logic	err
);

	////////////////////////////////////////////////////////////////////////////
	// Internal AXI4-Lite link
	////////////////////////////////////////////////////////////////////////////

	axil_if bus ();

	mem_sys_axil i_master (
		.clk		(clk),
		.rst_n		(rst_n),
		.addr		(addr),
		.data_in	(data_in),
		.wr			(wr),
		.rd			(rd),
		.valid		(valid),
		.be			(be),
		.data_out	(data_out),
		.done		(done),
		.err		(err),
		.bus		(bus.master)
	);

	// On-chip RAM, the only slave
	axil_ram i_ram (
		.clk		(clk),
		.rst_n		(rst_n),
		.bus		(bus.slave)
	);

endmodule : mem_sys_top

//--- tests/mem_sys_tb.sv
// Testbench for the memory system with clock, reset, LFSR stimulus, reference model and checks
`timescale 1ns/1ns

module mem_sys_tb import mem_sys_pkg::*;;

	localparam int N_TRANS     = 289;				// 1 + 32 + 32 + 24 + 200
	localparam int CYCLE_LIMIT = N_TRANS * 8 + 200;

	logic	clk, rst_n;
	addr_t	addr;
	data_t	data_in, data_out;
	logic	wr, rd, valid, done, err;
	strb_t	be;

	int		value_errors = 0;
	int		proto_errors = 0;
	int		cycle_count = 0;
	logic [31:0] lfsr_state = 32'd72;

	data_t	ref_mem [int];					// Expected RAM words
	strb_t	known [int];					// Lanes written so far
	int		written [$];

	mem_sys_top i_dut (.*);

	////////////////////////////////////////////////////////////////////////////
	// Clock, timeout and random bits
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic lfsr_step();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb)
			lfsr_state = lfsr_state ^ 32'h8020_0003;	// x^32 + x^22 + x^2 + x + 1
		return lsb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	function automatic logic in_range(input addr_t a);
		return a[31:10] == '0;
	endfunction

	// Random low bits with high bits set only for out of range
	function automatic addr_t make_addr(input logic oor);
		logic [21:0] high;
		logic [9:0]  low;
		high = oor ? 22'(rand_bits(22)) : '0;
		if (oor && high == '0)
			high = 22'h1;
		low = 10'(rand_bits(10));
		return {high, low};
	endfunction

	task automatic report_value(input string name, input data_t exp, input data_t got);
		$display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
		value_errors++;
	endtask

	task automatic report_proto(input string what);
		$display("Protocol error at %0t ns: %s", $time, what);
		proto_errors++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Request tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic access(input logic is_wr, input addr_t a, input data_t d, input strb_t b,
		output data_t rdata, output logic rerr);
		int cycles;
		@(negedge clk);
		addr    = a;
		data_in = d;
		be      = b;
		wr      = is_wr;
		rd      = ~is_wr;
		valid   = 1'b1;
		cycles  = 0;
		do begin
			@(negedge clk);						// done is steady mid cycle
			cycles++;
		end while (!done && cycles < 8);
		if (!done) begin
			$display("No done within 8 cycles for the request to address %h", a);
			$display("Test failed");
			$finish;
		end
		rdata = data_out;
		rerr  = err;
		@(posedge clk);							// End of the done cycle
	endtask

	task automatic go_idle();
		@(negedge clk);
		valid = 1'b0;
		rd    = 1'b0;
		wr    = 1'b0;
	endtask

	task automatic write_check(input addr_t a, input data_t d, input strb_t b);
		data_t rdata, word;
		logic  rerr;
		int    idx;
		access(1'b1, a, d, b, rdata, rerr);
		assert (rerr == !in_range(a)) else report_value("err", !in_range(a), rerr);
		if (in_range(a)) begin
			idx = int'(a[9:2]);
			if (!ref_mem.exists(idx)) begin
				ref_mem[idx] = '0;
				known[idx]   = '0;
			end
			word = ref_mem[idx];
			for (int i = 0; i < BYTES; i++) begin
				if (b[i]) begin
					word[8*i +: 8] = d[8*i +: 8];	// Merge enabled lanes
					known[idx][i]  = 1'b1;
				end
			end
			ref_mem[idx] = word;
		end
	endtask

	task automatic read_check(input addr_t a);
		data_t rdata, exp, mask;
		logic  rerr;
		int    idx;
		access(1'b0, a, '0, '0, rdata, rerr);
		idx  = int'(a[9:2]);
		exp  = '0;
		mask = '1;								// Out of range reads give zero
		if (in_range(a)) begin
			mask = '0;
			if (ref_mem.exists(idx)) begin
				exp = ref_mem[idx];
				for (int i = 0; i < BYTES; i++)
					if (known[idx][i])
						mask[8*i +: 8] = 8'hff;
			end
		end
		assert (rerr == !in_range(a)) else report_value("err", !in_range(a), rerr);
		assert ((rdata & mask) == (exp & mask))
			else report_value("data_out", exp & mask, rdata & mask);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Protocol properties
	////////////////////////////////////////////////////////////////////////////

	wire ar_hs = i_dut.bus.arvalid & i_dut.bus.arready;
	wire r_hs  = i_dut.bus.rvalid & i_dut.bus.rready;
	wire aw_hs = i_dut.bus.awvalid & i_dut.bus.awready;
	wire b_hs  = i_dut.bus.bvalid & i_dut.bus.bready;

	assert property (@(posedge clk) !rst_n |-> (!done && !err))
		else report_proto("done or err high during reset");
	assert property (@(posedge clk) disable iff (!rst_n) done |-> valid)
		else report_proto("done high without a valid request");
	assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else report_proto("done held for more than one cycle");
	assert property (@(posedge clk) disable iff (!rst_n) err |-> done)
		else report_proto("err high outside a done cycle");

	int   rd_wait, wr_wait;
	logic rd_open, wr_open;

	// Edges counted from the address handshake up to the eighth
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_open <= 1'b0;
			wr_open <= 1'b0;
		end else begin
			if (ar_hs) begin
				rd_open <= 1'b1;
				rd_wait <= 1;
			end else if (r_hs) begin
				rd_open <= 1'b0;
			end else if (rd_open) begin
				assert (rd_wait < 8)
					else report_proto("no read data 8 cycles after read address");
				rd_wait <= rd_wait + 1;
				if (rd_wait >= 8)
					rd_open <= 1'b0;
			end
			if (aw_hs) begin
				wr_open <= 1'b1;
				wr_wait <= 1;
			end else if (b_hs) begin
				wr_open <= 1'b0;
			end else if (wr_open) begin
				assert (wr_wait < 8)
					else report_proto("no write response 8 cycles after address");
				wr_wait <= wr_wait + 1;
				if (wr_wait >= 8)
					wr_open <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		addr_t a, q [$];
		int    idx;
		rst_n   = 1'b0;
		addr    = '0;
		data_in = '0;
		wr      = 1'b0;
		rd      = 1'b0;
		valid   = 1'b0;
		be      = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (!done) else report_value("done", '0, done);
		assert (!err) else report_value("err", '0, err);

		// First request after reset
		a = make_addr(1'b0);
		write_check(a, rand_bits(32), 4'hf);
		written.push_back(int'(a[9:2]));

		// Full words read back with new low bits
		for (int i = 0; i < 16; i++) begin
			a = make_addr(1'b0);
			q.push_back(a);
			written.push_back(int'(a[9:2]));
			write_check(a, rand_bits(32), 4'hf);
		end
		foreach (q[i])
			read_check({q[i][31:2], 2'(rand_bits(2))});

		// Byte strobes on words already known
		for (int i = 0; i < 16; i++) begin
			idx = written[rand_bits(5) % written.size()];
			a   = {22'h0, 8'(idx), 2'(rand_bits(2))};
			write_check(a, rand_bits(32), 4'(rand_bits(4)));
			read_check(a);
		end

		// Out of range reads and then writes that alias a known word
		for (int i = 0; i < 8; i++)
			read_check(make_addr(1'b1));
		for (int i = 0; i < 8; i++) begin
			idx = written[rand_bits(5) % written.size()];
			a   = make_addr(1'b1);
			a[9:2] = 8'(idx);
			write_check(a, rand_bits(32), 4'hf);
			read_check({22'h0, 8'(idx), 2'b00});
		end

		// Random mix issued back to back
		for (int i = 0; i < 200; i++) begin
			a = make_addr(rand_bits(3) == 0);
			if (rand_bits(1))
				write_check(a, rand_bits(32), 4'(rand_bits(4)));
			else
				read_check(a);
		end
		go_idle();
		repeat (4) @(posedge clk);

		$display("Value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule : mem_sys_tb

//--- project.f
logic/mem_sys_pkg.sv
logic/axil_if.sv
logic/mem_sys_axil.sv
logic/axil_ram.sv
logic/mem_sys_top.sv
tests/mem_sys_tb.sv
